// ==== bench/clusterChecker.sv ====
`timescale 1ns/1ps

module clusterChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  oooPkg::dispatchT dispatch,
    input  oooPkg::cdbT      extCdb,
    input  logic             full,
    input  oooPkg::exResultT result,
    output int               errorCount,
    output int               resultCount,
    output int               openCount
);
    import rvOpPkg::*;
    import oooPkg::*;

    localparam int NumNicks = 1 << NickWidth;

    typedef struct packed {
        dataT data;
        logic jump;
        addrT jumpPc;
    } expectT;

    // one record per nick whose operands fill in as the buses deliver them
    dispatchT rec [NumNicks];
    logic     isOpen [NumNicks];
    logic     wasRst = 1'b0;
    int       errors = 0;
    int       seen = 0;
    int       openNow = 0;

    assign errorCount  = errors;
    assign resultCount = seen;
    assign openCount   = openNow;

    initial begin
        for (int i = 0; i < NumNicks; i++) begin
            isOpen[i] = 1'b0;
        end
    end

    // ========================================
    // reference model
    // ========================================
    function automatic logic signedLess(dataT x, dataT y);
        return (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);
    endfunction

    function automatic expectT refExecute(aluOpT op, addrT pc, dataT imm, dataT a, dataT b);
        expectT     e;
        dataT       rhs;
        logic [4:0] sh;
        e.data   = '0;
        e.jump   = NotJump;
        e.jumpPc = pc + imm;
        rhs = (op inside {OpAddi, OpSlti, OpSltiu, OpXori, OpOri, OpAndi,
                          OpSlli, OpSrli, OpSrai}) ? imm : b;
        sh  = rhs[4:0];
        case (op)
            OpLui:   e.data = imm;
            OpAuipc: e.data = pc + imm;
            OpJal: begin
                e.data = pc + 32'd4;
                e.jump = Jump;
            end
            OpJalr: begin
                e.data   = pc + 32'd4;
                e.jump   = Jump;
                e.jumpPc = a + imm;
            end
            OpBeq:  e.jump = (a == b) ? Jump : NotJump;
            OpBne:  e.jump = (a != b) ? Jump : NotJump;
            OpBlt:  e.jump = signedLess(a, b) ? Jump : NotJump;
            OpBge:  e.jump = signedLess(a, b) ? NotJump : Jump;
            OpBltu: e.jump = (a < b) ? Jump : NotJump;
            OpBgeu: e.jump = (a < b) ? NotJump : Jump;
            OpAddi, OpAdd:   e.data = a + rhs;
            OpSub:           e.data = a - b;
            OpSlti, OpSlt:   e.data = signedLess(a, rhs) ? 32'd1 : 32'd0;
            OpSltiu, OpSltu: e.data = (a < rhs) ? 32'd1 : 32'd0;
            OpXori, OpXor:   e.data = a ^ rhs;
            OpOri, OpOr:     e.data = a | rhs;
            OpAndi, OpAnd:   e.data = a & rhs;
            OpSlli, OpSll:   e.data = a << sh;
            OpSrli, OpSrl:   e.data = a >> sh;
            // sign fill done by hand from the top bit
            OpSrai, OpSra:   e.data = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            default: ;
        endcase
        return e;
    endfunction

    // ========================================
    // operand tracking
    // ========================================
    function automatic srcT fillSrc(srcT s, cdbT bus);
        srcT r;
        r = s;
        if (!s.ready && s.opnd.tag.nick == bus.nick) begin
            r.ready      = 1'b1;
            r.opnd.value = bus.data;
        end
        return r;
    endfunction

    task automatic wakeAll(cdbT bus);
        for (int i = 0; i < NumNicks; i++) begin
            if (isOpen[i]) begin
                rec[i].src1 = fillSrc(rec[i].src1, bus);
                rec[i].src2 = fillSrc(rec[i].src2, bus);
            end
        end
    endtask

    task automatic recordDispatch();
        if (isOpen[dispatch.rdNick]) begin
            errors++;
            $display("at %0t nick %0d was dispatched again while still in flight",
                     $time, dispatch.rdNick);
        end else begin
            openNow++;
        end
        rec[dispatch.rdNick]    = dispatch;
        isOpen[dispatch.rdNick] = 1'b1;
    endtask

    task automatic checkResult();
        nickT     n;
        dispatchT d;
        expectT   e;
        n = result.cdb.nick;
        seen++;
        if (!isOpen[n]) begin
            errors++;
            $display("at %0t a result came for nick %0d with no instruction in flight", $time, n);
            return;
        end
        d         = rec[n];
        isOpen[n] = 1'b0;
        openNow--;
        if (!d.src1.ready || !d.src2.ready) begin
            errors++;
            $display("at %0t nick %0d finished before its operands were broadcast", $time, n);
            return;
        end
        e = refExecute(d.op, d.pc, d.imm, d.src1.opnd.value, d.src2.opnd.value);
        if (result.cdb.data !== e.data) begin
            errors++;
            $display("CHECK FAILED at %0t: nick %0d %s data %h, expected %h",
                     $time, n, d.op.name(), result.cdb.data, e.data);
        end
        if (result.jump !== e.jump) begin
            errors++;
            $display("CHECK FAILED at %0t: nick %0d %s jump %b, expected %b",
                     $time, n, d.op.name(), result.jump, e.jump);
        end
        if (d.op inside {OpJal, OpJalr, OpBeq, OpBne, OpBlt, OpBge, OpBltu, OpBgeu}
                && result.jumpPc !== e.jumpPc) begin
            errors++;
            $display("CHECK FAILED at %0t: nick %0d %s jump pc %h, expected %h",
                     $time, n, d.op.name(), result.jumpPc, e.jumpPc);
        end
    endtask

    // ========================================
    // compare process
    // ========================================
    always @(posedge clk) begin
        if (rst) begin
            wasRst = 1'b1;
        end else begin
            if (wasRst && (result.cdb.valid !== 1'b0 || full !== 1'b0)) begin
                errors++;
                $display("CHECK FAILED at %0t: after reset result.valid %b full %b, expected 0 0",
                         $time, result.cdb.valid, full);
            end
            wasRst = 1'b0;
            // the bus only counts while the core is not stalled
            if (rdy) begin
                if (result.cdb.valid) begin
                    checkResult();
                end
                if (dispatch.valid && !full) begin
                    recordDispatch();
                end
                if (result.cdb.valid) begin
                    wakeAll(result.cdb);
                end
                if (extCdb.valid) begin
                    wakeAll(extCdb);
                end
            end
        end
    end

endmodule

// ==== bench/tbAluCluster.sv ====
`timescale 1ns/1ps

module tbAluCluster;
    import rvOpPkg::*;
    import oooPkg::*;

    localparam int RsDepth   = 4;
    localparam int NumInstr  = 400;
    localparam int ClkPeriod = 10;
    localparam int NumNicks  = 1 << NickWidth;
    localparam int KindFree  = 0;
    localparam int KindAlu   = 1;
    localparam int KindLoad  = 2;

    logic     clk = 1'b0;
    logic     rst;
    logic     rdy;
    dispatchT dispatch;
    cdbT      extCdb;
    logic     full;
    exResultT result;

    int errorCount;
    int resultCount;
    int openCount;
    int benchErrors = 0;
    int sent = 0;
    int stallLeft = 0;

    logic [31:0] lfsr = 32'd74616;
    nickT        freeNicks [$];
    nickT        loadsPending [$];
    int          kind [NumNicks];

    aluOpT opList [29] = '{OpLui, OpAuipc, OpJal, OpJalr, OpBeq, OpBne, OpBlt, OpBge,
                           OpBltu, OpBgeu, OpAddi, OpSlti, OpSltiu, OpXori, OpOri,
                           OpAndi, OpSlli, OpSrli, OpSrai, OpAdd, OpSub, OpSll, OpSlt,
                           OpSltu, OpXor, OpSrl, OpSra, OpOr, OpAnd};

    always #(ClkPeriod / 2) clk = ~clk;

    aluCluster #(
        .RsDepth (RsDepth)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .dispatch (dispatch),
        .extCdb   (extCdb),
        .full     (full),
        .result   (result)
    );

    clusterChecker checker0 (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .dispatch    (dispatch),
        .extCdb      (extCdb),
        .full        (full),
        .result      (result),
        .errorCount  (errorCount),
        .resultCount (resultCount),
        .openCount   (openCount)
    );

    // ========================================
    // random source
    // ========================================
    function automatic logic stepLfsr();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], stepLfsr()};
        end
        return r;
    endfunction

    // small values make equal compares and short shifts likely
    function automatic dataT randomWord();
        if (randBits(2) == 0) begin
            return randBits(2);
        end
        return randBits(32);
    endfunction

    function automatic dataT makeImm(aluOpT op);
        logic [31:0] r;
        if (op == OpLui || op == OpAuipc) begin
            r = randBits(20);
            return {r[19:0], 12'd0};
        end
        r = randBits(12);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic srcT makeSrc(logic haveBc, nickT bc);
        nickT        alu [$];
        srcT         s;
        logic [31:0] pick;
        for (int i = 0; i < NumNicks; i++) begin
            if (kind[i] == KindAlu) begin
                alu.push_back(nickT'(i));
            end
        end
        s    = '0;
        pick = randBits(2);
        if (pick == 1 && alu.size() > 0) begin
            s.opnd.tag.nick = alu[randBits(4) % alu.size()];
        end else if (pick == 2 && haveBc && randBits(1) == 1) begin
            s.opnd.tag.nick = bc;
        end else if (pick == 2 && loadsPending.size() > 0) begin
            s.opnd.tag.nick = loadsPending[randBits(3) % loadsPending.size()];
        end else begin
            s.ready      = 1'b1;
            s.opnd.value = randomWord();
        end
        return s;
    endfunction

    // ========================================
    // driver
    // ========================================
    task automatic driveCycle();
        logic     haveBc;
        nickT     bc;
        nickT     n;
        dispatchT d;
        haveBc = 1'b0;
        bc     = '0;
        d      = '0;
        extCdb = '0;
        if (stallLeft > 0) begin
            rdy = 1'b0;
            stallLeft--;
        end else if (randBits(4) == 0) begin
            rdy       = 1'b0;
            stallLeft = randBits(2);
        end else begin
            rdy = 1'b1;
        end
        if (rdy) begin
            if (sent < NumInstr && loadsPending.size() < 3 && freeNicks.size() > 0
                    && randBits(3) == 0) begin
                n       = freeNicks.pop_front();
                kind[n] = KindLoad;
                loadsPending.push_back(n);
            end
            if (loadsPending.size() > 0 && (sent >= NumInstr || randBits(2) == 0)) begin
                haveBc      = 1'b1;
                bc          = loadsPending.pop_front();
                extCdb.valid = 1'b1;
                extCdb.nick  = bc;
                extCdb.data  = randBits(32);
            end
            if (sent < NumInstr && !full && freeNicks.size() > 0 && randBits(3) != 0) begin
                d.valid  = 1'b1;
                d.op     = opList[randBits(5) % 29];
                d.pc     = randBits(32) & 32'hFFFF_FFFC;
                d.imm    = makeImm(d.op);
                d.src1   = makeSrc(haveBc, bc);
                d.src2   = makeSrc(haveBc, bc);
                d.rdNick = freeNicks.pop_front();
                kind[d.rdNick] = KindAlu;
                sent++;
            end
        end
        dispatch = d;
    endtask

    task automatic freeNick(nickT n);
        kind[n] = KindFree;
        freeNicks.push_back(n);
    endtask

    // a nick is free again once its broadcast has been taken
    always @(posedge clk) begin
        if (!rst && rdy) begin
            if (result.cdb.valid && kind[result.cdb.nick] == KindAlu) begin
                freeNick(result.cdb.nick);
            end
            if (extCdb.valid) begin
                freeNick(extCdb.nick);
            end
        end
    end

    initial begin
        rst      = 1'b1;
        rdy      = 1'b0;
        dispatch = '0;
        extCdb   = '0;
        for (int i = 0; i < NumNicks; i++) begin
            freeNicks.push_back(nickT'(i));
            kind[i] = KindFree;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (sent < NumInstr || freeNicks.size() < NumNicks) begin
            driveCycle();
            @(posedge clk);
            #1;
        end
        // no result may show up in the quiet tail
        dispatch = '0;
        extCdb   = '0;
        rdy      = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        if (resultCount != NumInstr) begin
            benchErrors++;
            $display("expected %0d results but %0d were seen", NumInstr, resultCount);
        end
        if (openCount != 0) begin
            benchErrors++;
            $display("%0d dispatched instructions never produced a result", openCount);
        end
        $display("errors: %0d (checker %0d, bench %0d), results seen: %0d",
                 errorCount + benchErrors, errorCount, benchErrors, resultCount);
        if (errorCount + benchErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ========================================
    // watchdog
    // ========================================
    initial begin
        #(NumInstr * 20 * ClkPeriod);
        $display("timeout: the run did not finish within %0d cycles", NumInstr * 20);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== design/aluCluster.sv ====
`timescale 1ns/1ps

module aluCluster #(
    parameter int RsDepth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  oooPkg::dispatchT dispatch,
    input  oooPkg::cdbT      extCdb,
    output logic             full,
    output oooPkg::exResultT result
);
    import oooPkg::*;

    issueT issue;
    cdbT   ownCdb;

    // own results wake up waiting entries next to the external bus
    assign ownCdb = result.cdb;

    // ========================================
    // reservation station
    // ========================================
    rsQueue #(
        .RsDepth (RsDepth)
    ) rsQueue0 (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .dispatch (dispatch),
        .ownCdb   (ownCdb),
        .extCdb   (extCdb),
        .full     (full),
        .issue    (issue)
    );

    // ========================================
    // execute unit
    // ========================================
    execute execute0 (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .issue  (issue),
        .result (result)
    );

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  oooPkg::issueT    issue,
    output oooPkg::exResultT result
);
    import rvOpPkg::*;

    dataT       opB;
    dataT       aluOut;
    addrT       target;
    logic       taken;
    logic [4:0] shamt;
    logic       isImm;
    logic       eq;
    logic       ltS;
    logic       ltU;

    // ========================================
    // operand select and compare
    // ========================================
    always_comb begin
        isImm = issue.op inside {OpAddi, OpSlti, OpSltiu, OpXori, OpOri, OpAndi,
                                 OpSlli, OpSrli, OpSrai};
        opB   = isImm ? issue.imm : issue.rs2;
        shamt = opB[4:0];
        // branches always compare the two registers
        eq    = issue.rs1 == issue.rs2;
        ltS   = $signed(issue.rs1) < $signed(issue.rs2);
        ltU   = issue.rs1 < issue.rs2;
    end

    // ========================================
    // alu and branch resolution
    // ========================================
    always_comb begin
        aluOut = '0;
        taken  = NotJump;
        target = issue.pc + issue.imm;
        case (issue.op)
            OpLui: aluOut = issue.imm;
            OpAuipc: aluOut = issue.pc + issue.imm;
            OpJal: begin
                aluOut = issue.pc + 32'd4;
                taken  = Jump;
            end
            OpJalr: begin
                aluOut = issue.pc + 32'd4;
                taken  = Jump;
                target = issue.rs1 + issue.imm;
            end

            // branches jump only when the compare holds and leave data at zero
            OpBeq:  taken = eq ? Jump : NotJump;
            OpBne:  taken = !eq ? Jump : NotJump;
            OpBlt:  taken = ltS ? Jump : NotJump;
            OpBge:  taken = !ltS ? Jump : NotJump;
            OpBltu: taken = ltU ? Jump : NotJump;
            OpBgeu: taken = !ltU ? Jump : NotJump;

            OpAddi, OpAdd: aluOut = issue.rs1 + opB;
            OpSub: aluOut = issue.rs1 - opB;
            OpSlti, OpSlt: aluOut = {31'd0, $signed(issue.rs1) < $signed(opB)};
            OpSltiu, OpSltu: aluOut = {31'd0, issue.rs1 < opB};
            OpXori, OpXor: aluOut = issue.rs1 ^ opB;
            OpOri, OpOr: aluOut = issue.rs1 | opB;
            OpAndi, OpAnd: aluOut = issue.rs1 & opB;
            OpSlli, OpSll: aluOut = issue.rs1 << shamt;
            OpSrli, OpSrl: aluOut = issue.rs1 >> shamt;
            OpSrai, OpSra: aluOut = dataT'($signed(issue.rs1) >>> shamt);
            default: aluOut = '0;
        endcase
    end

    // ========================================
    // result register onto the bus
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            result.cdb.valid <= 1'b0;
        end else if (rdy) begin
            result.cdb.valid <= issue.valid;
            if (issue.valid) begin
                result.cdb.nick <= issue.rdNick;
                result.cdb.data <= aluOut;
                result.jump     <= taken;
                result.jumpPc   <= target;
            end
        end
    end

endmodule

// ==== design/oooPkg.sv ====
package oooPkg;

    // ========================================
    // rename tags
    // ========================================
    localparam int NickWidth = 4;

    typedef logic [NickWidth-1:0] nickT;

    // one operand word holding a value once ready and the producer's nick before that
    typedef union packed {
        rvOpPkg::dataT value;
        struct packed {
            logic [rvOpPkg::XLen-NickWidth-1:0] pad;
            nickT                               nick;
        } tag;
    } operandU;

    typedef struct packed {
        logic    ready;
        operandU opnd;
    } srcT;

    // ========================================
    // pipeline messages
    // ========================================
    typedef struct packed {
        logic           valid;
        rvOpPkg::aluOpT op;
        rvOpPkg::addrT  pc;
        rvOpPkg::dataT  imm;
        nickT           rdNick;
        srcT            src1;
        srcT            src2;
    } dispatchT;

    typedef struct packed {
        logic           valid;
        rvOpPkg::aluOpT op;
        rvOpPkg::addrT  pc;
        rvOpPkg::dataT  imm;
        nickT           rdNick;
        rvOpPkg::dataT  rs1;
        rvOpPkg::dataT  rs2;
    } issueT;

    // common data bus
    typedef struct packed {
        logic          valid;
        nickT          nick;
        rvOpPkg::dataT data;
    } cdbT;

    // bus message plus the branch outcome for the reorder buffer
    typedef struct packed {
        cdbT           cdb;
        logic          jump;
        rvOpPkg::addrT jumpPc;
    } exResultT;

endpackage

// ==== design/rsQueue.sv ====
`timescale 1ns/1ps

module rsQueue #(
    parameter int RsDepth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  oooPkg::dispatchT dispatch,
    input  oooPkg::cdbT      ownCdb,
    input  oooPkg::cdbT      extCdb,
    output logic             full,
    output oooPkg::issueT    issue
);
    import oooPkg::*;

    localparam int IdxW = (RsDepth > 1) ? $clog2(RsDepth) : 1;

    // slot 0 holds the oldest entry and valid entries stay packed at the bottom
    dispatchT slot [RsDepth];
    dispatchT woken [RsDepth];
    dispatchT slotNext [RsDepth];
    dispatchT incoming;
    issueT    issueNext;

    logic [RsDepth-1:0] ready;
    logic [IdxW-1:0]    selIdx;
    logic               selFound;
    logic               accept;
    logic               appendDone;

    // replaces a waiting nick by the bus value when either bus carries it
    function automatic srcT wakeSrc(srcT s, cdbT busA, cdbT busB);
        srcT r;
        r = s;
        if (!s.ready) begin
            if (busA.valid && busA.nick == s.opnd.tag.nick) begin
                r.ready      = 1'b1;
                r.opnd.value = busA.data;
            end else if (busB.valid && busB.nick == s.opnd.tag.nick) begin
                r.ready      = 1'b1;
                r.opnd.value = busB.data;
            end
        end
        return r;
    endfunction

    // ========================================
    // wakeup and bypass
    // ========================================
    always_comb begin
        for (int i = 0; i < RsDepth; i++) begin
            woken[i]      = slot[i];
            woken[i].src1 = wakeSrc(slot[i].src1, ownCdb, extCdb);
            woken[i].src2 = wakeSrc(slot[i].src2, ownCdb, extCdb);
            ready[i]      = slot[i].valid && woken[i].src1.ready && woken[i].src2.ready;
        end
        // a tag broadcast in the dispatch cycle is captured here
        incoming      = dispatch;
        incoming.src1 = wakeSrc(dispatch.src1, ownCdb, extCdb);
        incoming.src2 = wakeSrc(dispatch.src2, ownCdb, extCdb);
    end

    always_comb begin
        full = 1'b1;
        for (int i = 0; i < RsDepth; i++) begin
            full = full & slot[i].valid;
        end
    end

    assign accept = dispatch.valid && !full;

    // ========================================
    // oldest-ready select
    // ========================================
    always_comb begin
        selIdx   = '0;
        selFound = 1'b0;
        for (int i = RsDepth - 1; i >= 0; i--) begin
            if (ready[i]) begin
                selIdx   = IdxW'(i);
                selFound = 1'b1;
            end
        end
        issueNext.valid  = selFound;
        issueNext.op     = woken[selIdx].op;
        issueNext.pc     = woken[selIdx].pc;
        issueNext.imm    = woken[selIdx].imm;
        issueNext.rdNick = woken[selIdx].rdNick;
        issueNext.rs1    = woken[selIdx].src1.opnd.value;
        issueNext.rs2    = woken[selIdx].src2.opnd.value;
    end

    // ========================================
    // compaction and append
    // ========================================
    always_comb begin
        appendDone = 1'b0;
        for (int i = 0; i < RsDepth; i++) begin
            if (selFound && i >= int'(selIdx)) begin
                // younger entries slide down over the issued one
                slotNext[i] = woken[(i < RsDepth - 1) ? i + 1 : i];
                if (i == RsDepth - 1) begin
                    slotNext[i].valid = 1'b0;
                end
            end else begin
                slotNext[i] = woken[i];
            end
        end
        for (int i = 0; i < RsDepth; i++) begin
            if (accept && !appendDone && !slotNext[i].valid) begin
                slotNext[i] = incoming;
                appendDone  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RsDepth; i++) begin
                slot[i].valid <= 1'b0;
            end
            issue.valid <= 1'b0;
        end else if (rdy) begin
            for (int i = 0; i < RsDepth; i++) begin
                slot[i] <= slotNext[i];
            end
            issue <= issueNext;
        end
    end

endmodule

// ==== design/rvOpPkg.sv ====
package rvOpPkg;

    // ========================================
    // data and address widths
    // ========================================
    localparam int XLen = 32;

    typedef logic [XLen-1:0] dataT;
    typedef logic [XLen-1:0] addrT;

    // jump flag towards the reorder buffer
    localparam logic NotJump = 1'b0;
    localparam logic Jump    = 1'b1;

    // ========================================
    // operation codes
    // ========================================
    // grouped so that each class sits in its own range
    typedef enum logic [5:0] {
        OpLui   = 6'd0,
        OpAuipc = 6'd1,
        OpJal   = 6'd2,
        OpJalr  = 6'd3,
        // conditional branches
        OpBeq   = 6'd8,
        OpBne   = 6'd9,
        OpBlt   = 6'd10,
        OpBge   = 6'd11,
        OpBltu  = 6'd12,
        OpBgeu  = 6'd13,
        // register-immediate alu
        OpAddi  = 6'd16,
        OpSlti  = 6'd17,
        OpSltiu = 6'd18,
        OpXori  = 6'd19,
        OpOri   = 6'd20,
        OpAndi  = 6'd21,
        OpSlli  = 6'd22,
        OpSrli  = 6'd23,
        OpSrai  = 6'd24,
        // register-register alu
        OpAdd   = 6'd32,
        OpSub   = 6'd33,
        OpSll   = 6'd34,
        OpSlt   = 6'd35,
        OpSltu  = 6'd36,
        OpXor   = 6'd37,
        OpSrl   = 6'd38,
        OpSra   = 6'd39,
        OpOr    = 6'd40,
        OpAnd   = 6'd41
    } aluOpT;

endpackage

// ==== list.f ====
design/rvOpPkg.sv
design/oooPkg.sv
design/rsQueue.sv
design/execute.sv
design/aluCluster.sv
bench/clusterChecker.sv
bench/tbAluCluster.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tbAluCluster -o simAluCluster

./obj_dir/simAluCluster > sim.log 2>&1
cat sim.log

if grep -qxF "All tests passed!" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
